// File: source/fetch_pkg.sv
package fetch_pkg;

	//////////////////////////////////////////////////
	// geometry
	//////////////////////////////////////////////////

	localparam int XLEN        = 32;
	localparam int INST_W      = 32;
	// two instructions per line
	localparam int LINE_W      = 2 * INST_W;
	localparam int MEM_TAG_W   = 4;
	localparam int IDX_W       = 5;
	localparam int CTAG_W      = XLEN - IDX_W - 3;
	localparam int CACHE_LINES = 1 << IDX_W;

	typedef logic [XLEN-1:0]      xlen_t;
	typedef logic [INST_W-1:0]    inst_t;
	typedef logic [LINE_W-1:0]    line_t;
	// zero here means busy or nothing on the bus
	typedef logic [MEM_TAG_W-1:0] mem_tag_t;
	typedef logic [IDX_W-1:0]     cache_idx_t;
	typedef logic [CTAG_W-1:0]    cache_tag_t;

	localparam xlen_t RESET_PC = '0;

	// memory bus command, store never issued by fetch
	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_cmd_e;

	// miss controller states
	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		WAIT_DATA
	} ctrl_state_e;

endpackage

// File: source/fetch_pc_counter.sv
`timescale 1ns/1ps

module fetch_pc_counter
	import fetch_pkg::*;
(
	input  logic  clock,
	input  logic  rst_n,
	// current pc found in the cache
	input  logic  hit,
	// downstream not ready
	input  logic  stall,
	// redirect from later stage
	input  logic  redirect_en,
	input  xlen_t redirect_pc,
	output xlen_t pc
);

	//////////////////////////////////////////////////
	// pc register
	//////////////////////////////////////////////////

	xlen_t pc_q;
	xlen_t pc_next;

	// one word per delivered instruction
	localparam xlen_t PC_STEP = xlen_t'(4);

	always_comb begin
		// default hold
		pc_next = pc_q;
		if (redirect_en) begin
			// redirect wins over advance
			pc_next = redirect_pc;
		end else if (hit && !stall) begin
			// instruction taken this cycle
			pc_next = pc_q + PC_STEP;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pc_q <= RESET_PC;
		end else begin
			pc_q <= pc_next;
		end
	end

	assign pc = pc_q;

endmodule

// File: source/icache_mem.sv
`timescale 1ns/1ps

module icache_mem
	import fetch_pkg::*;
(
	input  logic       clock,
	input  logic       rst_n,
	// lookup address
	input  xlen_t      pc,
	// line fill from the miss controller
	input  logic       fill_en,
	input  cache_idx_t fill_idx,
	input  cache_tag_t fill_tag,
	input  line_t      fill_data,
	output logic       hit,
	output inst_t      inst
);

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////

	logic [CACHE_LINES-1:0] valid_q;
	cache_tag_t             tag_q  [CACHE_LINES];
	line_t                  line_q [CACHE_LINES];

	// valid bits only, contents are don't care until filled
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (fill_en) begin
			valid_q[fill_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (fill_en) begin
			tag_q[fill_idx]  <= fill_tag;
			line_q[fill_idx] <= fill_data;
		end
	end

	//////////////////////////////////////////////////
	// combinational read
	//////////////////////////////////////////////////

	cache_idx_t rd_idx;
	cache_tag_t rd_tag;
	line_t      rd_line;

	// index bits 7:3, tag bits 31:8
	assign rd_idx  = pc[7:3];
	assign rd_tag  = pc[31:8];
	assign rd_line = line_q[rd_idx];

	assign hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

	// pc bit 2 picks upper word
	assign inst = pc[2] ? rd_line[LINE_W-1:INST_W] : rd_line[INST_W-1:0];

endmodule

// File: source/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
	import fetch_pkg::*;
(
	input  logic       clock,
	input  logic       rst_n,
	// fetch address and lookup result
	input  xlen_t      pc,
	input  logic       hit,
	// memory side
	input  mem_tag_t   mem2proc_response,
	input  mem_tag_t   mem2proc_tag,
	input  line_t      mem2proc_data,
	output bus_cmd_e   proc2mem_command,
	output xlen_t      proc2mem_addr,
	// fill port into the line store
	output logic       fill_en,
	output cache_idx_t fill_idx,
	output cache_tag_t fill_tag,
	output line_t      fill_data
);

	//////////////////////////////////////////////////
	// state and miss registers
	//////////////////////////////////////////////////

	ctrl_state_e state_q;
	ctrl_state_e state_next;

	// line address of the outstanding miss
	cache_idx_t miss_idx_q;
	cache_tag_t miss_tag_q;
	// tag the memory handed back on acceptance
	mem_tag_t   pend_tag_q;

	logic       accept;
	logic       data_match;

	// nonzero response in REQUEST means memory took it
	assign accept     = (state_q == REQUEST) && (mem2proc_response != '0);
	// data for our request, other tags are dropped
	assign data_match = (state_q == WAIT_DATA) && (mem2proc_tag == pend_tag_q);

	always_comb begin
		state_next = state_q;
		unique case (state_q)
			IDLE: begin
				// miss on current pc starts a line fetch
				if (!hit) begin
					state_next = REQUEST;
				end
			end
			REQUEST: begin
				// hold command until memory is not busy
				if (accept) begin
					state_next = WAIT_DATA;
				end
			end
			WAIT_DATA: begin
				if (data_match) begin
					state_next = IDLE;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_next;
		end
	end

	// latch line address at miss detect
	always_ff @(posedge clock) begin
		if ((state_q == IDLE) && !hit) begin
			miss_idx_q <= pc[7:3];
			miss_tag_q <= pc[31:8];
		end
	end

	// response value becomes the pending tag
	always_ff @(posedge clock) begin
		if (accept) begin
			pend_tag_q <= mem2proc_response;
		end
	end

	//////////////////////////////////////////////////
	// outputs
	//////////////////////////////////////////////////

	assign proc2mem_command = (state_q == REQUEST) ? BUS_LOAD : BUS_NONE;

	// line aligned, low three bits zero
	assign proc2mem_addr = (state_q == REQUEST) ? {miss_tag_q, miss_idx_q, 3'b000} : '0;

	// single cycle write strobe on matching data
	assign fill_en   = data_match;
	assign fill_idx  = miss_idx_q;
	assign fill_tag  = miss_tag_q;
	assign fill_data = mem2proc_data;

endmodule

// File: source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
	import fetch_pkg::*;
(
	input  logic     clock,
	input  logic     rst_n,
	// downstream control
	input  logic     stall,
	input  logic     redirect_en,
	input  xlen_t    redirect_pc,
	// memory bus
	input  mem_tag_t mem2proc_response,
	input  mem_tag_t mem2proc_tag,
	input  line_t    mem2proc_data,
	output bus_cmd_e proc2mem_command,
	output xlen_t    proc2mem_addr,
	// one instruction per cycle on hit
	output logic     fetch_valid,
	output xlen_t    fetch_pc,
	output inst_t    fetch_inst
);

	//////////////////////////////////////////////////
	// internal wires
	//////////////////////////////////////////////////

	xlen_t      pc;
	logic       hit;
	inst_t      inst;

	// controller to line store
	logic       fill_en;
	cache_idx_t fill_idx;
	cache_tag_t fill_tag;
	line_t      fill_data;

	fetch_pc_counter pc_counter_0 (
		.clock       (clock),
		.rst_n       (rst_n),
		.hit         (hit),
		.stall       (stall),
		.redirect_en (redirect_en),
		.redirect_pc (redirect_pc),
		.pc          (pc)
	);

	icache_mem icache_mem_0 (
		.clock     (clock),
		.rst_n     (rst_n),
		.pc        (pc),
		.fill_en   (fill_en),
		.fill_idx  (fill_idx),
		.fill_tag  (fill_tag),
		.fill_data (fill_data),
		.hit       (hit),
		.inst      (inst)
	);

	icache_ctrl icache_ctrl_0 (
		.clock             (clock),
		.rst_n             (rst_n),
		.pc                (pc),
		.hit               (hit),
		.mem2proc_response (mem2proc_response),
		.mem2proc_tag      (mem2proc_tag),
		.mem2proc_data     (mem2proc_data),
		.proc2mem_command  (proc2mem_command),
		.proc2mem_addr     (proc2mem_addr),
		.fill_en           (fill_en),
		.fill_idx          (fill_idx),
		.fill_tag          (fill_tag),
		.fill_data         (fill_data)
	);

	// valid independent of stall
	assign fetch_valid = hit;
	assign fetch_pc    = pc;
	assign fetch_inst  = inst;

endmodule

// File: include/mem_image.svh
// memory image used by the bus model and the checkers
// upper half is the inverted low address half

function automatic inst_t image_word(input xlen_t a);
	return {~a[15:0], a[15:0]};
endfunction

// whole line, bit 2 picks the upper word
function automatic line_t image_line(input xlen_t a);
	xlen_t base;
	base = {a[31:3], 3'b000};
	return {image_word(base + 32'd4), image_word(base)};
endfunction

// File: sim/fetch_sva.sv
`timescale 1ns/1ps

module fetch_sva
	import fetch_pkg::*;
(
	input logic     clock,
	input logic     rst_n,
	input logic     stall,
	input logic     fetch_valid,
	input xlen_t    fetch_pc,
	input inst_t    fetch_inst,
	input bus_cmd_e proc2mem_command,
	input xlen_t    proc2mem_addr,
	input mem_tag_t mem2proc_response
);

	`include "mem_image.svh"

	// read by the testbench at the end of the run
	int fail_count = 0;

	//////////////////////////////////////////////////
	// reset and delivery
	//////////////////////////////////////////////////

	// first cycle out of reset is quiet
	reset_idle: assert property (@(posedge clock)
		$rose(rst_n) |-> (!fetch_valid && proc2mem_command == BUS_NONE))
	else begin
		fail_count++;
		$error("FAILED %0t fetch_valid got %b expected 0, proc2mem_command got %0d expected 0",
			$time, $sampled(fetch_valid), $sampled(proc2mem_command));
	end

	// delivered word must match the image at its pc
	inst_image: assert property (@(posedge clock) disable iff (!rst_n)
		(fetch_valid && !stall) |-> (fetch_inst == image_word(fetch_pc)))
	else begin
		fail_count++;
		$error("FAILED %0t fetch_inst got %h expected %h",
			$time, $sampled(fetch_inst), image_word($sampled(fetch_pc)));
	end

	//////////////////////////////////////////////////
	// bus rules
	//////////////////////////////////////////////////

	addr_aligned: assert property (@(posedge clock) disable iff (!rst_n)
		(proc2mem_command == BUS_LOAD) |-> (proc2mem_addr[2:0] == 3'b000))
	else begin
		fail_count++;
		$error("FAILED %0t proc2mem_addr got %h expected low bits 000",
			$time, $sampled(proc2mem_addr));
	end

	// busy answer means same request again next cycle
	req_hold: assert property (@(posedge clock) disable iff (!rst_n)
		(proc2mem_command == BUS_LOAD && mem2proc_response == '0)
		|=> (proc2mem_command == BUS_LOAD && $stable(proc2mem_addr)))
	else begin
		fail_count++;
		$error("bus load dropped or its address moved before acceptance at %0t", $time);
	end

	no_store: assert property (@(posedge clock) disable iff (!rst_n)
		proc2mem_command != BUS_STORE)
	else begin
		fail_count++;
		$error("fetch issued a store command on the bus at %0t", $time);
	end

endmodule

// File: sim/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch
	import fetch_pkg::*;
();

	`include "mem_image.svh"

	localparam int          DELIVERIES     = 200;
	// worst miss from busy answers plus data delay
	localparam int          MISS_BOUND     = 20;
	localparam int          TIMEOUT_CYCLES = DELIVERIES * MISS_BOUND + 500;
	localparam logic [31:0] SEED           = 32'hff58_4c49;
	// forward, odd word, back to 0
	localparam int          REDIR_AT [3]   = '{24, 48, 63};
	localparam xlen_t       REDIR_PC [3]   = '{32'h0000_0860, 32'h0000_0cc4, 32'h0000_0000};

	logic       clock;
	logic       rst_n;
	logic       stall;
	logic       redirect_en;
	xlen_t      redirect_pc;
	mem_tag_t   mem2proc_response;
	mem_tag_t   mem2proc_tag;
	line_t      mem2proc_data;
	bus_cmd_e   proc2mem_command;
	xlen_t      proc2mem_addr;
	logic       fetch_valid;
	xlen_t      fetch_pc;
	inst_t      fetch_inst;

	logic [31:0] rng;
	int          errors;
	int          deliveries;
	int          tb_cycle;
	int          redir_step;
	// single outstanding line request
	logic        out_valid;
	mem_tag_t    out_tag;
	xlen_t       out_addr;
	int          out_due;
	logic        fill_pending;
	xlen_t       fill_addr;
	mem_tag_t    next_tag;
	mem_tag_t    junk_tag;
	logic        seen_accept;
	// lines the cache should hold
	logic        res_valid [CACHE_LINES];
	cache_tag_t  res_tag   [CACHE_LINES];
	xlen_t       expect_pc;
	logic        held;
	xlen_t       held_pc;
	inst_t       held_inst;

	fetch_top DUT (.*);

	bind fetch_top fetch_sva fetch_sva_0 (.*);

	always #20 clock = ~clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic is_resident(input xlen_t a);
		return res_valid[a[7:3]] && (res_tag[a[7:3]] == a[31:8]);
	endfunction

	//////////////////////////////////////////////////
	// memory model, checks, stimulus
	//////////////////////////////////////////////////

	always @(posedge clock) begin
		if (rst_n) begin
			tb_cycle++;
			rng = xorshift32(rng);
			// request seen this cycle
			if (proc2mem_command == BUS_LOAD) begin
				assert (!is_resident(proc2mem_addr)) else begin
					errors++;
					$display("bus load at %0t for line %h that is already cached",
						$time, proc2mem_addr);
				end
				if (mem2proc_response != '0) begin
					assert (seen_accept || proc2mem_addr == RESET_PC) else begin
						errors++;
						$display("FAILED %0t proc2mem_addr got %h expected %h",
							$time, proc2mem_addr, RESET_PC);
					end
					seen_accept = 1'b1;
					out_valid = 1'b1;
					out_tag = mem2proc_response;
					out_addr = proc2mem_addr;
					out_due = tb_cycle + 1 + (int'(rng[10:8]) % 6);
					next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
				end
			end
			// data driven last cycle was written at this edge
			if (fill_pending) begin
				res_valid[fill_addr[7:3]] = 1'b1;
				res_tag[fill_addr[7:3]] = fill_addr[31:8];
				fill_pending = 1'b0;
			end
			junk_tag = mem_tag_t'(rng[19:16]);
			if (junk_tag == '0) begin
				junk_tag = 4'd1;
			end
			if (out_valid && junk_tag == out_tag) begin
				junk_tag = (out_tag == 4'd15) ? 4'd1 : out_tag + 4'd1;
			end
			if (out_valid && tb_cycle >= out_due) begin
				mem2proc_tag <= out_tag;
				mem2proc_data <= image_line(out_addr);
				fill_addr = out_addr;
				fill_pending = 1'b1;
				out_valid = 1'b0;
			end else if (rng[7:6] == 2'b00) begin
				// stray tag with noise that must be ignored
				mem2proc_tag <= junk_tag;
				mem2proc_data <= {rng, ~rng};
			end else begin
				mem2proc_tag <= '0;
			end
			// zero answer means busy
			mem2proc_response <= (rng[1:0] == 2'b00) ? mem_tag_t'(0) : next_tag;

			// delivery order
			if (fetch_valid && !stall) begin
				assert (fetch_pc == expect_pc) else begin
					errors++;
					$display("FAILED %0t fetch_pc got %h expected %h", $time, fetch_pc, expect_pc);
				end
				deliveries++;
				expect_pc = expect_pc + 32'd4;
			end
			// stalled output holds
			if (held) begin
				assert (fetch_pc == held_pc) else begin
					errors++;
					$display("FAILED %0t fetch_pc got %h expected %h", $time, fetch_pc, held_pc);
				end
				assert (!fetch_valid || fetch_inst == held_inst) else begin
					errors++;
					$display("FAILED %0t fetch_inst got %h expected %h",
						$time, fetch_inst, held_inst);
				end
			end
			held = fetch_valid && stall && !redirect_en;
			held_pc = fetch_pc;
			held_inst = fetch_inst;
			if (redirect_en) begin
				expect_pc = redirect_pc;
			end

			redirect_en <= 1'b0;
			stall <= (rng[13:12] == 2'b00);
			// stall the redirect cycle so nothing is delivered in it
			if (redir_step < 3 && deliveries >= REDIR_AT[redir_step]) begin
				redirect_en <= 1'b1;
				redirect_pc <= REDIR_PC[redir_step];
				stall <= 1'b1;
				redir_step++;
			end
		end
	end

	//////////////////////////////////////////////////
	// run control
	//////////////////////////////////////////////////

	initial begin
		int cycles;
		int total;
		clock = 1'b0;
		rst_n = 1'b0;
		stall = 1'b0;
		redirect_en = 1'b0;
		redirect_pc = '0;
		mem2proc_response = '0;
		mem2proc_tag = '0;
		mem2proc_data = '0;
		rng = SEED;
		errors = 0;
		deliveries = 0;
		tb_cycle = 0;
		redir_step = 0;
		out_valid = 1'b0;
		out_tag = '0;
		out_addr = '0;
		out_due = 0;
		fill_pending = 1'b0;
		fill_addr = '0;
		next_tag = 4'd1;
		junk_tag = '0;
		seen_accept = 1'b0;
		expect_pc = RESET_PC;
		held = 1'b0;
		held_pc = '0;
		held_inst = '0;
		for (int i = 0; i < CACHE_LINES; i++) begin
			res_valid[i] = 1'b0;
			res_tag[i] = '0;
		end
		cycles = 0;
		repeat (2) @(posedge clock);
		rst_n <= 1'b1;
		while (deliveries < DELIVERIES && cycles < TIMEOUT_CYCLES) begin
			@(negedge clock);
			cycles++;
		end
		if (deliveries < DELIVERIES) begin
			errors++;
			$display("timeout after %0d cycles with only %0d deliveries", cycles, deliveries);
		end
		total = errors + DUT.fetch_sva_0.fail_count;
		$display("deliveries %0d, testbench errors %0d, assertion errors %0d",
			deliveries, errors, DUT.fetch_sva_0.fail_count);
		if (total == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: sim.f
+incdir+include
source/fetch_pkg.sv
source/fetch_pc_counter.sv
source/icache_mem.sv
source/icache_ctrl.sv
source/fetch_top.sv
sim/fetch_sva.sv
sim/tb_fetch.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - files:
      - source/fetch_pkg.sv
      - source/fetch_pc_counter.sv
      - source/icache_mem.sv
      - source/icache_ctrl.sv
      - source/fetch_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/fetch_sva.sv
      - sim/tb_fetch.sv
